//--- source/frontend_settings.svh
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

`define FE_ADDR_W      32
`define FE_DATA_W      32
// instructions per bundle, also the fetch burst length in beats
`define FE_ISSUE_W     2
`define FE_ID_W        4
`define FE_ID_FETCH    1
`define FE_ID_LOAD     0
`define FE_BUF_DEPTH   4
`define FE_RESET_PC    32'h0000_0000

// arsize code for four-byte beats, arburst code for INCR
`define FE_BEAT_SIZE   3'd2
`define FE_BURST_INCR  2'b01

`endif

//--- source/frontend_pkg.sv
`include "frontend_settings.svh"

`default_nettype none

package frontend_pkg;

    // read address channel request
    typedef struct packed {
        logic [`FE_ID_W-1:0]   id;
        logic [`FE_ADDR_W-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_ar_t;

    // one read data beat
    typedef struct packed {
        logic [`FE_ID_W-1:0]   id;
        logic [`FE_DATA_W-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } axi_r_t;

    // pc redirect from a later stage
    typedef struct packed {
        logic                  valid;
        logic [`FE_ADDR_W-1:0] target;
    } redirect_t;

    // insn[0] sits at pc, insn[1] at pc + 4
    typedef struct packed {
        logic [`FE_ADDR_W-1:0]                  pc;
        logic [`FE_ISSUE_W-1:0][`FE_DATA_W-1:0] insn;
    } fetch_bundle_t;

endpackage

`default_nettype wire

//--- source/fetch_engine.sv
`include "frontend_settings.svh"

`default_nettype none

module fetch_engine (
    input  wire                           aclk,
    input  wire                           aresetn,
    input  wire frontend_pkg::redirect_t  i_redir_wb,
    input  wire frontend_pkg::redirect_t  i_redir_ex,
    input  wire frontend_pkg::redirect_t  i_redir_id,
    output frontend_pkg::axi_ar_t         o_ar,
    output logic                          o_ar_valid,
    input  wire                           i_ar_ready,
    input  wire frontend_pkg::axi_r_t     i_r,
    input  wire                           i_r_valid,
    output logic                          o_r_ready,
    output frontend_pkg::fetch_bundle_t   o_push_bundle,
    output logic                          o_push_valid,
    input  wire                           i_push_ready,
    output logic                          o_flush
);

    localparam int BEAT_W = (`FE_ISSUE_W > 1) ? $clog2(`FE_ISSUE_W) : 1;
    localparam logic [`FE_ADDR_W-1:0] BUNDLE_BYTES = `FE_ADDR_W'(`FE_ISSUE_W * `FE_DATA_W / 8);
    localparam logic [`FE_ADDR_W-1:0] ALIGN_MASK = ~(BUNDLE_BYTES - 1'b1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_BEATS
    } state_t;

    state_t                      state;
    logic [`FE_ADDR_W-1:0]       pc;
    frontend_pkg::redirect_t     redir;
    frontend_pkg::fetch_bundle_t bundle_q;
    logic [BEAT_W-1:0]           beat_idx;
    logic                        stale;
    logic                        push_q;
    logic                        start;
    logic                        ar_done;
    logic                        beat_done;

    // writeback over execute over decode
    always_comb begin
        if (i_redir_wb.valid) begin
            redir = i_redir_wb;
        end else if (i_redir_ex.valid) begin
            redir = i_redir_ex;
        end else begin
            redir = i_redir_id;
        end
    end

    // new fetch only with a free buffer slot and no push still pending
    assign start     = (state == S_IDLE) && i_push_ready && !push_q && !redir.valid;
    assign ar_done   = (state == S_ADDR) && i_ar_ready;
    assign beat_done = (state == S_BEATS) && i_r_valid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state    <= S_IDLE;
            pc       <= `FE_RESET_PC;
            stale    <= 1'b0;
            push_q   <= 1'b0;
            beat_idx <= '0;
        end else begin
            push_q <= beat_done && i_r.last && !stale && !redir.valid;

            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_ADDR;
                        stale <= 1'b0;
                    end
                end
                S_ADDR: begin
                    if (i_ar_ready) begin
                        state    <= S_BEATS;
                        beat_idx <= '0;
                    end
                end
                S_BEATS: begin
                    if (i_r_valid) begin
                        beat_idx <= beat_idx + 1'b1;
                        if (i_r.last) begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase

            // an in-flight fetch still runs to the end, its bundle is dropped
            if (redir.valid) begin
                pc <= redir.target & ALIGN_MASK;
                if (state != S_IDLE) begin
                    stale <= 1'b1;
                end
            end else if (ar_done && !stale) begin
                pc <= pc + BUNDLE_BYTES;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            bundle_q.pc <= pc;
        end
        if (beat_done) begin
            bundle_q.insn[beat_idx] <= i_r.data;
        end
    end

    always_comb begin
        o_ar.id    = `FE_ID_W'(`FE_ID_FETCH);
        o_ar.addr  = bundle_q.pc;
        o_ar.len   = 8'(`FE_ISSUE_W - 1);
        o_ar.size  = `FE_BEAT_SIZE;
        o_ar.burst = `FE_BURST_INCR;
    end

    assign o_ar_valid    = (state == S_ADDR);
    assign o_r_ready     = (state == S_BEATS);
    assign o_push_bundle = bundle_q;
    assign o_push_valid  = push_q;
    assign o_flush       = redir.valid;

endmodule

`default_nettype wire

//--- source/fetch_buffer.sv
`include "frontend_settings.svh"

`default_nettype none

module fetch_buffer #(
    parameter int DEPTH = `FE_BUF_DEPTH
) (
    input  wire                               aclk,
    input  wire                               aresetn,
    input  wire                               i_flush,
    input  wire frontend_pkg::fetch_bundle_t  i_bundle,
    input  wire                               i_valid,
    output logic                              o_ready,
    output frontend_pkg::fetch_bundle_t       o_bundle,
    output logic                              o_valid,
    input  wire                               i_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    frontend_pkg::fetch_bundle_t mem [DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [CNT_W-1:0]            count;
    logic                        push;
    logic                        pop;

    // wraps at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_ready  = (count < CNT_W'(DEPTH));
    assign o_valid  = (count != '0);
    assign o_bundle = mem[rd_ptr];
    assign push     = i_valid && o_ready;
    assign pop      = o_valid && i_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= i_bundle;
        end
    end

endmodule

`default_nettype wire

//--- source/load_port.sv
`include "frontend_settings.svh"

`default_nettype none

module load_port (
    input  wire                        aclk,
    input  wire                        aresetn,
    input  wire [`FE_ADDR_W-1:0]       i_addr,
    input  wire                        i_valid,
    output logic                       o_ready,
    output frontend_pkg::axi_ar_t      o_ar,
    output logic                       o_ar_valid,
    input  wire                        i_ar_ready,
    input  wire frontend_pkg::axi_r_t  i_r,
    input  wire                        i_r_valid,
    output logic                       o_r_ready,
    output logic [`FE_DATA_W-1:0]      o_data,
    output logic                       o_resp_valid,
    input  wire                        i_resp_ready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA
    } state_t;

    state_t                state;
    logic                  ready_q;
    logic                  resp_valid;
    logic [`FE_ADDR_W-1:0] addr_q;
    logic [`FE_DATA_W-1:0] data_q;
    logic                  accept;
    logic                  beat;

    assign accept = i_valid && ready_q;
    assign beat   = i_r_valid && o_r_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= S_IDLE;
            ready_q    <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (i_ar_ready) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (beat) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase

            // reopen only once the previous response is claimed
            if (accept) begin
                ready_q <= 1'b0;
            end else if (state == S_IDLE && (!resp_valid || i_resp_ready)) begin
                ready_q <= 1'b1;
            end

            if (beat) begin
                resp_valid <= 1'b1;
            end else if (i_resp_ready) begin
                resp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q <= i_addr;
        end
        if (beat) begin
            data_q <= i_r.data;
        end
    end

    always_comb begin
        o_ar.id    = `FE_ID_W'(`FE_ID_LOAD);
        o_ar.addr  = addr_q;
        o_ar.len   = 8'd0;
        o_ar.size  = `FE_BEAT_SIZE;
        o_ar.burst = `FE_BURST_INCR;
    end

    assign o_ready      = ready_q;
    assign o_ar_valid   = (state == S_ADDR);
    // no new beat while the held response is unclaimed
    assign o_r_ready    = (state == S_DATA) && !resp_valid;
    assign o_data       = data_q;
    assign o_resp_valid = resp_valid;

endmodule

`default_nettype wire

//--- source/axi_read_arbiter.sv
`include "frontend_settings.svh"

`default_nettype none

module axi_read_arbiter (
    input  wire                        aclk,
    input  wire                        aresetn,
    input  wire frontend_pkg::axi_ar_t i_fetch_ar,
    input  wire frontend_pkg::axi_ar_t i_load_ar,
    input  wire                        i_fetch_ar_valid,
    input  wire                        i_load_ar_valid,
    output logic                       o_fetch_ar_ready,
    output logic                       o_load_ar_ready,
    output frontend_pkg::axi_ar_t      o_ar,
    output logic                       o_ar_valid,
    input  wire                        i_ar_ready,
    input  wire frontend_pkg::axi_r_t  i_r,
    input  wire                        i_r_valid,
    output logic                       o_r_ready,
    output logic                       o_fetch_r_valid,
    output logic                       o_load_r_valid,
    input  wire                        i_fetch_r_ready,
    input  wire                        i_load_r_ready
);

    logic locked;
    logic lock_load;
    logic sel_load;
    logic r_is_load;
    logic r_is_fetch;

    // free grant favours the load side, a stalled grant stays put
    assign sel_load = locked ? lock_load : i_load_ar_valid;

    assign o_ar             = sel_load ? i_load_ar : i_fetch_ar;
    assign o_ar_valid       = sel_load ? i_load_ar_valid : i_fetch_ar_valid;
    assign o_load_ar_ready  = sel_load && i_ar_ready;
    assign o_fetch_ar_ready = !sel_load && i_ar_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            locked    <= 1'b0;
            lock_load <= 1'b0;
        end else if (o_ar_valid && !i_ar_ready) begin
            locked    <= 1'b1;
            lock_load <= sel_load;
        end else if (i_ar_ready) begin
            locked    <= 1'b0;
        end
    end

    // response beats go back by arid
    assign r_is_load  = (i_r.id == `FE_ID_W'(`FE_ID_LOAD));
    assign r_is_fetch = (i_r.id == `FE_ID_W'(`FE_ID_FETCH));

    assign o_load_r_valid  = i_r_valid && r_is_load;
    assign o_fetch_r_valid = i_r_valid && r_is_fetch;
    assign o_r_ready       = r_is_load ? i_load_r_ready : (r_is_fetch && i_fetch_r_ready);

endmodule

`default_nettype wire

//--- source/core_frontend.sv
`include "frontend_settings.svh"

`default_nettype none

module core_frontend (
    input  wire                               aclk,
    input  wire                               aresetn,
    output frontend_pkg::axi_ar_t             o_axi_ar,
    output logic                              o_axi_arvalid,
    input  wire                               i_axi_arready,
    input  wire frontend_pkg::axi_r_t         i_axi_r,
    input  wire                               i_axi_rvalid,
    output logic                              o_axi_rready,
    input  wire frontend_pkg::redirect_t      i_redir_wb,
    input  wire frontend_pkg::redirect_t      i_redir_ex,
    input  wire frontend_pkg::redirect_t      i_redir_id,
    output frontend_pkg::fetch_bundle_t       o_bundle,
    output logic                              o_bundle_valid,
    input  wire                               i_bundle_ready,
    input  wire [`FE_ADDR_W-1:0]              i_load_addr,
    input  wire                               i_load_valid,
    output logic                              o_load_ready,
    output logic [`FE_DATA_W-1:0]             o_load_data,
    output logic                              o_load_resp_valid,
    input  wire                               i_load_resp_ready
);

    frontend_pkg::axi_ar_t       fetch_ar;
    frontend_pkg::axi_ar_t       load_ar;
    frontend_pkg::fetch_bundle_t push_bundle;
    logic                        fetch_ar_valid;
    logic                        fetch_ar_ready;
    logic                        load_ar_valid;
    logic                        load_ar_ready;
    logic                        fetch_r_valid;
    logic                        fetch_r_ready;
    logic                        load_r_valid;
    logic                        load_r_ready;
    logic                        push_valid;
    logic                        push_ready;
    logic                        flush;

    fetch_engine u_fetch_engine (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_redir_wb    (i_redir_wb),
        .i_redir_ex    (i_redir_ex),
        .i_redir_id    (i_redir_id),
        .o_ar          (fetch_ar),
        .o_ar_valid    (fetch_ar_valid),
        .i_ar_ready    (fetch_ar_ready),
        .i_r           (i_axi_r),
        .i_r_valid     (fetch_r_valid),
        .o_r_ready     (fetch_r_ready),
        .o_push_bundle (push_bundle),
        .o_push_valid  (push_valid),
        .i_push_ready  (push_ready),
        .o_flush       (flush)
    );

    fetch_buffer #(
        .DEPTH (`FE_BUF_DEPTH)
    ) u_fetch_buffer (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .i_flush  (flush),
        .i_bundle (push_bundle),
        .i_valid  (push_valid),
        .o_ready  (push_ready),
        .o_bundle (o_bundle),
        .o_valid  (o_bundle_valid),
        .i_ready  (i_bundle_ready)
    );

    load_port u_load_port (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_addr       (i_load_addr),
        .i_valid      (i_load_valid),
        .o_ready      (o_load_ready),
        .o_ar         (load_ar),
        .o_ar_valid   (load_ar_valid),
        .i_ar_ready   (load_ar_ready),
        .i_r          (i_axi_r),
        .i_r_valid    (load_r_valid),
        .o_r_ready    (load_r_ready),
        .o_data       (o_load_data),
        .o_resp_valid (o_load_resp_valid),
        .i_resp_ready (i_load_resp_ready)
    );

    axi_read_arbiter u_axi_read_arbiter (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .i_fetch_ar       (fetch_ar),
        .i_load_ar        (load_ar),
        .i_fetch_ar_valid (fetch_ar_valid),
        .i_load_ar_valid  (load_ar_valid),
        .o_fetch_ar_ready (fetch_ar_ready),
        .o_load_ar_ready  (load_ar_ready),
        .o_ar             (o_axi_ar),
        .o_ar_valid       (o_axi_arvalid),
        .i_ar_ready       (i_axi_arready),
        .i_r              (i_axi_r),
        .i_r_valid        (i_axi_rvalid),
        .o_r_ready        (o_axi_rready),
        .o_fetch_r_valid  (fetch_r_valid),
        .o_load_r_valid   (load_r_valid),
        .i_fetch_r_ready  (fetch_r_ready),
        .i_load_r_ready   (load_r_ready)
    );

endmodule

`default_nettype wire

//--- test/axi_mem_model.sv
`include "frontend_settings.svh"

`default_nettype none

module axi_mem_model (
    input  wire                        aclk,
    input  wire                        aresetn,
    input  wire frontend_pkg::axi_ar_t i_ar,
    input  wire                        i_arvalid,
    output logic                       o_arready,
    output frontend_pkg::axi_r_t       o_r,
    output logic                       o_rvalid,
    input  wire                        i_rready
);

    timeunit 1ns;
    timeprecision 1ns;

    frontend_pkg::axi_ar_t bursts [$];
    frontend_pkg::axi_ar_t head;
    logic [7:0]            beat;
    logic [`FE_ADDR_W-1:0] beat_addr;
    integer                seed = 19;

    // upper half of the byte address inverted
    function automatic logic [`FE_DATA_W-1:0] mem_word(input logic [`FE_ADDR_W-1:0] addr);
        return addr ^ 32'hFFFF_0000;
    endfunction

    always @(posedge aclk) begin
        if (!aresetn) begin
            o_arready <= 1'b0;
            o_rvalid  <= 1'b0;
            o_r       <= '0;
            beat      = 8'd0;
            bursts.delete();
        end else begin
            if (i_arvalid && o_arready) begin
                bursts.push_back(i_ar);
            end
            o_arready <= (($random(seed) & 3) != 0);

            // a presented beat holds until rready
            if (!(o_rvalid && !i_rready)) begin
                if (o_rvalid) begin
                    if (o_r.last) begin
                        void'(bursts.pop_front());
                        beat = 8'd0;
                    end else begin
                        beat = beat + 8'd1;
                    end
                end
                if (bursts.size() > 0 && (($random(seed) & 3) != 0)) begin
                    head      = bursts[0];
                    beat_addr = head.addr + {22'd0, beat, 2'b00};
                    o_r <= '{id: head.id, data: mem_word(beat_addr), resp: 2'b00,
                             last: (beat == head.len)};
                    o_rvalid <= 1'b1;
                end else begin
                    o_rvalid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_core_frontend.sv
`include "frontend_settings.svh"

`default_nettype none

module tb_core_frontend;

    timeunit 1ns;
    timeprecision 1ns;

    // roughly 60 bundles and 12 loads at under 10 cycles each leave a wide margin
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int NUM_LOADS      = 12;

    logic                        aclk = 1'b0;
    logic                        aresetn;
    frontend_pkg::axi_ar_t       axi_ar;
    logic                        axi_arvalid;
    logic                        axi_arready;
    frontend_pkg::axi_r_t        axi_r;
    logic                        axi_rvalid;
    logic                        axi_rready;
    frontend_pkg::redirect_t     redir_wb;
    frontend_pkg::redirect_t     redir_ex;
    frontend_pkg::redirect_t     redir_id;
    frontend_pkg::fetch_bundle_t bundle;
    logic                        bundle_valid;
    logic                        bundle_ready;
    logic [`FE_ADDR_W-1:0]       load_addr;
    logic                        load_valid;
    logic                        load_ready;
    logic [`FE_DATA_W-1:0]       load_data;
    logic                        load_resp_valid;
    logic                        load_resp_ready;

    integer                      seed = 19;
    int                          cycle_count = 0;
    int                          cur_test = 1;
    int                          errors [1:6];
    int                          checks = 0;
    int                          bundle_count = 0;
    int                          fetch_ar_count = 0;
    int                          loads_done = 0;
    bit                          bp_check = 1'b1;
    bit                          first_ar_seen = 1'b0;
    logic [`FE_ADDR_W-1:0]       exp_pc = `FE_RESET_PC;
    logic [`FE_ADDR_W-1:0]       load_q [$];

    // previous cycle state for the held-payload checks
    bit                          ar_stalled = 1'b0;
    bit                          bundle_stalled = 1'b0;
    bit                          resp_stalled = 1'b0;
    bit                          flush_seen = 1'b0;
    frontend_pkg::axi_ar_t       ar_hold;
    frontend_pkg::fetch_bundle_t bundle_hold;
    logic [`FE_DATA_W-1:0]       resp_hold;

    always #50 aclk = ~aclk;

    core_frontend u_dut (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .o_axi_ar          (axi_ar),
        .o_axi_arvalid     (axi_arvalid),
        .i_axi_arready     (axi_arready),
        .i_axi_r           (axi_r),
        .i_axi_rvalid      (axi_rvalid),
        .o_axi_rready      (axi_rready),
        .i_redir_wb        (redir_wb),
        .i_redir_ex        (redir_ex),
        .i_redir_id        (redir_id),
        .o_bundle          (bundle),
        .o_bundle_valid    (bundle_valid),
        .i_bundle_ready    (bundle_ready),
        .i_load_addr       (load_addr),
        .i_load_valid      (load_valid),
        .o_load_ready      (load_ready),
        .o_load_data       (load_data),
        .o_load_resp_valid (load_resp_valid),
        .i_load_resp_ready (load_resp_ready)
    );

    axi_mem_model u_mem (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_ar      (axi_ar),
        .i_arvalid (axi_arvalid),
        .o_arready (axi_arready),
        .o_r       (axi_r),
        .o_rvalid  (axi_rvalid),
        .i_rready  (axi_rready)
    );

    function automatic logic [`FE_DATA_W-1:0] expected_word(input logic [`FE_ADDR_W-1:0] a);
        return {~a[31:16], a[15:0]};
    endfunction

    function automatic frontend_pkg::redirect_t make_redirect(input logic [`FE_ADDR_W-1:0] t);
        return '{valid: 1'b1, target: t};
    endfunction

    task automatic pulse_redirect(input frontend_pkg::redirect_t wb,
                                  input frontend_pkg::redirect_t ex,
                                  input frontend_pkg::redirect_t id);
        @(posedge aclk);
        redir_wb <= wb;
        redir_ex <= ex;
        redir_id <= id;
        @(posedge aclk);
        redir_wb <= '0;
        redir_ex <= '0;
        redir_id <= '0;
    endtask

    task automatic wait_bundles(input int n);
        int target;
        target = bundle_count + n;
        while (bundle_count < target) begin
            @(posedge aclk);
        end
    endtask

    task automatic issue_load(input logic [`FE_ADDR_W-1:0] a);
        @(posedge aclk);
        load_addr  <= a;
        load_valid <= 1'b1;
        @(negedge aclk);
        while (!load_ready) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        load_valid <= 1'b0;
    endtask

    task automatic report_test(input int n, input string name);
        $display("test %0d %s: %0d errors", n, name, errors[n]);
    endtask

    // sampled at the falling edge where outputs are stable
    always @(negedge aclk) begin : monitor
        frontend_pkg::redirect_t win;
        logic [`FE_ADDR_W-1:0]   a;
        if (aresetn) begin
            if (ar_stalled) begin
                checks++;
                assert (axi_arvalid && axi_ar == ar_hold) else begin
                    $display("Fail at %0t: AR payload changed while stalled", $time);
                    errors[6]++;
                end
            end
            if (bundle_stalled && !flush_seen) begin
                checks++;
                assert (bundle_valid && bundle == bundle_hold) else begin
                    $display("Fail at %0t: bundle changed while stalled", $time);
                    errors[6]++;
                end
            end
            if (resp_stalled) begin
                checks++;
                assert (load_resp_valid && load_data == resp_hold) else begin
                    $display("Fail at %0t: load response changed while stalled", $time);
                    errors[6]++;
                end
            end

            if (axi_arvalid && axi_arready) begin
                // four-byte beats in INCR bursts
                checks++;
                assert (axi_ar.size == 3'd2 && axi_ar.burst == 2'b01) else begin
                    $display("Fail at %0t: AR size %0d burst %0d", $time, axi_ar.size,
                             axi_ar.burst);
                    errors[cur_test]++;
                end
                if (!first_ar_seen) begin
                    checks++;
                    assert (axi_ar.id == `FE_ID_W'(`FE_ID_FETCH)
                            && axi_ar.addr == `FE_RESET_PC && axi_ar.len == 8'd1) else begin
                        $display("Fail at %0t: first AR id %0d addr %h len %0d", $time,
                                 axi_ar.id, axi_ar.addr, axi_ar.len);
                        errors[1]++;
                    end
                    first_ar_seen = 1'b1;
                end
                if (axi_ar.id == `FE_ID_W'(`FE_ID_LOAD)) begin
                    checks++;
                    assert (axi_ar.len == 8'd0 && load_q.size() > 0
                            && axi_ar.addr == load_q[load_q.size() - 1]) else begin
                        $display("Fail at %0t: load AR addr %h len %0d", $time,
                                 axi_ar.addr, axi_ar.len);
                        errors[4]++;
                    end
                end else begin
                    checks++;
                    assert (axi_ar.id == `FE_ID_W'(`FE_ID_FETCH) && axi_ar.len == 8'd1) else begin
                        $display("Fail at %0t: fetch AR id %0d len %0d", $time, axi_ar.id,
                                 axi_ar.len);
                        errors[cur_test]++;
                    end
                    if (bp_check) begin
                        checks++;
                        assert (fetch_ar_count - bundle_count < `FE_BUF_DEPTH) else begin
                            $display("Fail at %0t: fetch AR accepted with the buffer full",
                                     $time);
                            errors[5]++;
                        end
                    end
                    fetch_ar_count++;
                end
            end

            if (bundle_valid && bundle_ready) begin
                checks++;
                assert (bundle.pc == exp_pc) else begin
                    $display("Fail at %0t: bundle pc %h, expected %h", $time, bundle.pc, exp_pc);
                    errors[cur_test]++;
                end
                for (int slot = 0; slot < `FE_ISSUE_W; slot++) begin
                    a = exp_pc + 32'(4 * slot);
                    checks++;
                    assert (bundle.insn[slot] == expected_word(a)) else begin
                        $display("Fail at %0t: insn %0d at %h is %h, expected %h", $time, slot,
                                 a, bundle.insn[slot], expected_word(a));
                        errors[cur_test]++;
                    end
                end
                exp_pc = exp_pc + 32'd8;
                bundle_count++;
            end

            if (load_valid && load_ready) begin
                load_q.push_back(load_addr);
            end
            if (load_resp_valid && load_resp_ready) begin
                a = load_q.pop_front();
                checks++;
                assert (load_data == expected_word(a)) else begin
                    $display("Fail at %0t: load %h returned %h, expected %h", $time, a,
                             load_data, expected_word(a));
                    errors[4]++;
                end
                loads_done++;
            end

            // writeback beats execute beats decode
            flush_seen = redir_wb.valid || redir_ex.valid || redir_id.valid;
            if (flush_seen) begin
                win = redir_wb.valid ? redir_wb : (redir_ex.valid ? redir_ex : redir_id);
                exp_pc = {win.target[31:3], 3'b000};
                bp_check = 1'b0;
            end

            ar_stalled     = axi_arvalid && !axi_arready;
            ar_hold        = axi_ar;
            bundle_stalled = bundle_valid && !bundle_ready;
            bundle_hold    = bundle;
            resp_stalled   = load_resp_valid && !load_resp_ready;
            resp_hold      = load_data;
        end
    end

    always @(posedge aclk) begin
        if (aresetn) begin
            load_resp_ready <= (($random(seed) & 3) != 0);
        end
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int total;
        aresetn         = 1'b0;
        redir_wb        = '0;
        redir_ex        = '0;
        redir_id        = '0;
        bundle_ready    = 1'b1;
        load_addr       = '0;
        load_valid      = 1'b0;
        load_resp_ready = 1'b0;
        for (int i = 1; i <= 6; i++) begin
            errors[i] = 0;
        end

        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;

        // test 1 checks quiet outputs in the first cycle and the first fetch request
        @(negedge aclk);
        checks++;
        assert (!axi_arvalid && !axi_rready && !bundle_valid && !load_ready
                && !load_resp_valid) else begin
            $display("Fail at %0t: outputs active in the first cycle after reset", $time);
            errors[1]++;
        end
        while (!first_ar_seen) begin
            @(posedge aclk);
        end
        report_test(1, "reset and first fetch");

        cur_test = 2;
        wait_bundles(12);
        report_test(2, "bundle stream");

        cur_test = 5;
        @(posedge aclk);
        bundle_ready <= 1'b0;
        while (fetch_ar_count - bundle_count < `FE_BUF_DEPTH) begin
            @(posedge aclk);
        end
        repeat (30) @(posedge aclk);
        bundle_ready <= 1'b1;
        wait_bundles(8);
        report_test(5, "back-pressure");

        cur_test = 3;
        pulse_redirect('0, '0, make_redirect(32'h0000_1004));
        wait_bundles(4);
        pulse_redirect('0, make_redirect(32'h0000_2000), make_redirect(32'h0000_3000));
        wait_bundles(4);
        pulse_redirect(make_redirect(32'h0000_4008), make_redirect(32'h0000_5000),
                       make_redirect(32'h0000_6000));
        wait_bundles(4);
        report_test(3, "redirects");

        cur_test = 4;
        for (int i = 0; i < NUM_LOADS; i++) begin
            issue_load($random(seed) & 32'h0003_fffc);
        end
        while (loads_done < NUM_LOADS) begin
            @(posedge aclk);
        end
        wait_bundles(4);
        report_test(4, "loads beside fetches");

        report_test(6, "held handshakes");

        total = 0;
        for (int i = 1; i <= 6; i++) begin
            total += errors[i];
        end
        $display("checks %0d, bundles %0d, loads %0d, errors %0d", checks, bundle_count,
                 loads_done, total);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/frontend_pkg.sv
source/fetch_engine.sv
source/fetch_buffer.sv
source/load_port.sv
source/axi_read_arbiter.sv
source/core_frontend.sv
test/axi_mem_model.sv
test/tb_core_frontend.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_frontend
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "\*\*\* TEST PASSED \*\*\*"

clean:
	rm -rf $(BUILD_DIR)
